// ==== files.f ====
hdl/gb_mem_map_pkg.sv
hdl/gb_bus_pkg.sv
hdl/byte_ram.sv
hdl/oam_dma.sv
hdl/mmu.sv
hdl/gb_mem_top.sv
test/mmu_checker.sv
test/tb_gb_mem.sv

// ==== Bender.yml ====
package:
  name: gb_mem

sources:
  - hdl/gb_mem_map_pkg.sv
  - hdl/gb_bus_pkg.sv
  - hdl/byte_ram.sv
  - hdl/oam_dma.sv
  - hdl/mmu.sv
  - hdl/gb_mem_top.sv
  - target: test
    files:
      - test/mmu_checker.sv
      - test/tb_gb_mem.sv

// ==== test/tb_gb_mem.sv ====
`timescale 1ns/1ps

module tb_gb_mem;
  import gb_bus_pkg::*;
  import gb_mem_map_pkg::*;

  logic       clk;
  logic       rst_n;
  bus_req_t   cpu_req;
  logic [7:0] cpu_rdata;
  bus_req_t   cart_req;
  logic [7:0] cart_rdata;
  logic       dma_busy;

  logic [15:0] cart_last_addr;
  logic [7:0]  cart_last_data;
  int          busy_cycles = 0;

  gb_mem_top gb_mem_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_req    (cpu_req),
    .cpu_rdata  (cpu_rdata),
    .cart_req   (cart_req),
    .cart_rdata (cart_rdata),
    .dma_busy   (dma_busy)
  );

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Cartridge model, ROM and cart RAM both answer with a pattern of the address
  function automatic logic [7:0] cart_value(input logic [15:0] addr);
    logic [15:0] mixed;
    mixed = addr ^ 16'h005A;
    return mixed[7:0];
  endfunction

  // Only a strobed read gets the pattern back
  assign cart_rdata = cart_req.read_en ? cart_value(cart_req.addr) : 8'h00;

  always @(posedge clk) begin
    if (cart_req.write_en) begin
      cart_last_addr <= cart_req.addr;
      cart_last_data <= cart_req.wdata;
    end
  end

  // Sampled mid cycle, away from the DMA state update
  always @(negedge clk) begin
    if (dma_busy === 1'b1) begin
      busy_cycles <= busy_cycles + 1;
    end
  end

  task automatic abort_run();
    $display("Finished with errors");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch at %0t ns: %s expected %0h actual %0h", $time, what, expected,
               actual);
      abort_run();
    end
  endtask

  // Write is taken at the rising edge between two falling edges
  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    cpu_req = '{addr: addr, wdata: data, read_en: 1'b0, write_en: 1'b1};
    @(negedge clk);
    cpu_req = '0;
  endtask

  task automatic cpu_read_check(input logic [15:0] addr, input logic [7:0] expected);
    logic [7:0] actual;
    cpu_req = '{addr: addr, wdata: 8'h00, read_en: 1'b1, write_en: 1'b0};
    #10;
    actual = cpu_rdata;
    check_value($sformatf("read of %h", addr), 32'(expected), 32'(actual));
    @(negedge clk);
    cpu_req = '0;
  endtask

  task automatic wait_dma_done();
    int cycles;
    cycles = 0;
    while (dma_busy !== 1'b0 && cycles < 400) begin
      @(negedge clk);
      cycles++;
    end
    assert (dma_busy === 1'b0) else begin
      $display("Timeout at %0t ns: DMA never finished within 400 cycles", $time);
      abort_run();
    end
  endtask

  task automatic test_reset_state();
    check_value("dma_busy after reset", 32'd0, 32'(dma_busy));
    cpu_read_check(16'h8000, 8'hFF);
    cpu_read_check(16'hFF10, 8'hFF);
    cpu_read_check(16'hFEA0, 8'hFF);
  endtask

  task automatic test_wram_echo();
    logic [15:0] addr;
    logic [7:0]  data;
    for (int n = 0; n < 24; n++) begin
      addr = 16'hC000 | 16'($urandom() & 32'h1FFF);
      data = 8'($urandom());
      cpu_write(addr, data);
      cpu_read_check(addr, data);
      if (addr + 16'h2000 <= ECHO_END) begin
        cpu_read_check(addr + 16'h2000, data);
      end
    end
  endtask

  task automatic test_hram_oam();
    logic [7:0] hram_vals [HRAM_DEPTH];
    logic [7:0] oam_vals [OAM_BYTES];
    for (int i = 0; i < HRAM_DEPTH; i++) begin
      hram_vals[i] = 8'($urandom());
      cpu_write(HRAM_START + 16'(i), hram_vals[i]);
    end
    for (int i = 0; i < OAM_BYTES; i++) begin
      oam_vals[i] = 8'($urandom());
      cpu_write(OAM_START + 16'(i), oam_vals[i]);
    end
    for (int i = 0; i < HRAM_DEPTH; i++) begin
      cpu_read_check(HRAM_START + 16'(i), hram_vals[i]);
    end
    for (int i = 0; i < OAM_BYTES; i++) begin
      cpu_read_check(OAM_START + 16'(i), oam_vals[i]);
    end
  endtask

  task automatic test_cart_port();
    cpu_read_check(16'h0000, cart_value(16'h0000));
    cpu_read_check(16'h1234, cart_value(16'h1234));
    cpu_read_check(16'h7FFF, cart_value(16'h7FFF));
    cpu_read_check(16'hA000, cart_value(16'hA000));
    cpu_read_check(16'hBFFF, cart_value(16'hBFFF));
    cpu_write(16'hA123, 8'h3C);
    check_value("cart write addr", 32'h0000A123, 32'(cart_last_addr));
    check_value("cart write data", 32'h0000003C, 32'(cart_last_data));
    // Bank select style write into ROM space
    cpu_write(16'h2000, 8'h05);
    check_value("cart write addr", 32'h00002000, 32'(cart_last_addr));
    check_value("cart write data", 32'h00000005, 32'(cart_last_data));
  endtask

  task automatic test_dma_from_wram();
    logic [7:0] page_vals [OAM_BYTES];
    int         busy_before;
    for (int i = 0; i < OAM_BYTES; i++) begin
      page_vals[i] = 8'($urandom());
      cpu_write(16'hC100 + 16'(i), page_vals[i]);
    end
    busy_before = busy_cycles;
    cpu_write(DMA_REG_ADDR, 8'hC1);
    check_value("dma_busy after start", 32'd1, 32'(dma_busy));
    cpu_read_check(16'hC105, 8'hFF);
    cpu_write(16'hFF90, 8'hA5);
    cpu_read_check(16'hFF90, 8'hA5);
    cpu_read_check(DMA_REG_ADDR, 8'hC1);
    // Second start during the transfer must not change the source page
    cpu_write(DMA_REG_ADDR, 8'hD0);
    cpu_read_check(DMA_REG_ADDR, 8'hC1);
    wait_dma_done();
    check_value("DMA busy cycles", 32'(2 * OAM_BYTES), 32'(busy_cycles - busy_before));
    for (int i = 0; i < OAM_BYTES; i++) begin
      cpu_read_check(OAM_START + 16'(i), page_vals[i]);
    end
  endtask

  task automatic test_dma_from_cart();
    int busy_before;
    busy_before = busy_cycles;
    cpu_write(DMA_REG_ADDR, 8'h40);
    check_value("dma_busy after start", 32'd1, 32'(dma_busy));
    wait_dma_done();
    check_value("DMA busy cycles", 32'(2 * OAM_BYTES), 32'(busy_cycles - busy_before));
    for (int i = 0; i < OAM_BYTES; i++) begin
      cpu_read_check(OAM_START + 16'(i), cart_value(16'h4000 + 16'(i)));
    end
  endtask

  initial begin
    void'($urandom(11663));
    rst_n   = 1'b0;
    cpu_req = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset_state();
    test_wram_echo();
    test_hram_oam();
    test_cart_port();
    test_dma_from_wram();
    test_dma_from_cart();

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== test/mmu_checker.sv ====
`timescale 1ns/1ps

module mmu_checker (
  input logic                 clk,
  input logic                 rst_n,
  input gb_bus_pkg::bus_req_t cpu_req,
  input gb_bus_pkg::dma_req_t dma_req,
  input gb_bus_pkg::bus_req_t wram_req,
  input gb_bus_pkg::bus_req_t oam_req,
  input gb_bus_pkg::bus_req_t cart_req
);

  // CPU writes into work RAM are dropped for the whole transfer
  wram_no_write_in_dma: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(dma_req.active && wram_req.write_en)
  ) else $error("WRAM write strobe high while DMA is active");

  // OAM has two writers, never both and never outside their window
  oam_write_owner: assert property (
    @(posedge clk) disable iff (!rst_n)
    oam_req.write_en |->
      ((cpu_req.write_en && !dma_req.active) || (dma_req.active && dma_req.write_en))
  ) else $error("OAM write strobe high without a CPU write or a DMA write phase");

  cart_one_strobe: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(cart_req.read_en && cart_req.write_en)
  ) else $error("Cartridge read and write strobes high together");

endmodule

// Bound at the top level, where the mapper nets and the clock meet
bind gb_mem_top mmu_checker mmu_checker_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .cpu_req  (cpu_req),
  .dma_req  (dma_req),
  .wram_req (wram_req),
  .oam_req  (oam_req),
  .cart_req (cart_req)
);

// ==== hdl/gb_mem_top.sv ====
`timescale 1ns/1ps

module gb_mem_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  gb_bus_pkg::bus_req_t cpu_req,
  output logic [7:0]           cpu_rdata,
  output gb_bus_pkg::bus_req_t cart_req,
  input  logic [7:0]           cart_rdata,
  output logic                 dma_busy
);
  import gb_bus_pkg::*;

  dma_req_t   dma_req;
  logic [7:0] dma_rdata;
  logic       dma_start;
  logic [7:0] dma_src;

  bus_req_t   wram_req;
  bus_req_t   hram_req;
  bus_req_t   oam_req;
  logic [7:0] wram_rdata;
  logic [7:0] hram_rdata;
  logic [7:0] oam_rdata;

  assign dma_busy = dma_req.active;

  mmu mmu_inst (
    .cpu_req    (cpu_req),
    .cpu_rdata  (cpu_rdata),
    .dma_req    (dma_req),
    .dma_rdata  (dma_rdata),
    .dma_start  (dma_start),
    .dma_src    (dma_src),
    .wram_req   (wram_req),
    .hram_req   (hram_req),
    .oam_req    (oam_req),
    .cart_req   (cart_req),
    .wram_rdata (wram_rdata),
    .hram_rdata (hram_rdata),
    .oam_rdata  (oam_rdata),
    .cart_rdata (cart_rdata)
  );

  // Page number comes straight from the CPU write data
  oam_dma oam_dma_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (dma_start),
    .start_data (cpu_req.wdata),
    .rdata      (dma_rdata),
    .req        (dma_req),
    .src        (dma_src)
  );

  byte_ram #(
    .DEPTH (WRAM_DEPTH)
  ) wram_inst (
    .clk   (clk),
    .req   (wram_req),
    .rdata (wram_rdata)
  );

  byte_ram #(
    .DEPTH (HRAM_DEPTH)
  ) hram_inst (
    .clk   (clk),
    .req   (hram_req),
    .rdata (hram_rdata)
  );

  byte_ram #(
    .DEPTH (OAM_BYTES)
  ) oam_inst (
    .clk   (clk),
    .req   (oam_req),
    .rdata (oam_rdata)
  );

endmodule

// ==== hdl/mmu.sv ====
`timescale 1ns/1ps

module mmu (
  input  gb_bus_pkg::bus_req_t cpu_req,
  output logic [7:0]           cpu_rdata,
  input  gb_bus_pkg::dma_req_t dma_req,
  output logic [7:0]           dma_rdata,
  output logic                 dma_start,
  input  logic [7:0]           dma_src,
  output gb_bus_pkg::bus_req_t wram_req,
  output gb_bus_pkg::bus_req_t hram_req,
  output gb_bus_pkg::bus_req_t oam_req,
  output gb_bus_pkg::bus_req_t cart_req,
  input  logic [7:0]           wram_rdata,
  input  logic [7:0]           hram_rdata,
  input  logic [7:0]           oam_rdata,
  input  logic [7:0]           cart_rdata
);
  import gb_mem_map_pkg::*;

  logic        dma_active;
  logic [15:0] eff_addr;

  logic cpu_rd;
  logic cpu_wr;
  logic dma_rd;
  logic dma_wr;

  logic cart_sel;
  logic wram_sel;
  logic oam_sel;
  logic hram_sel;
  logic dma_reg_sel;

  // DMA owns the shared address for the whole transfer
  assign dma_active = dma_req.active;
  assign eff_addr   = dma_active ? dma_req.addr : cpu_req.addr;

  // CPU strobes are blocked while DMA runs, except for HRAM and FF46
  assign cpu_rd = cpu_req.read_en && !dma_active;
  assign cpu_wr = cpu_req.write_en && !dma_active;
  assign dma_rd = dma_req.read_en && dma_active;
  assign dma_wr = dma_req.write_en && dma_active;

  // Regions reachable by DMA decode the effective address
  assign cart_sel = eff_addr inside {[ROM_START : ROM_END], [CART_RAM_START : CART_RAM_END]};
  assign wram_sel = eff_addr inside {[WRAM_START : WRAM_END], [ECHO_START : ECHO_END]};
  assign oam_sel  = eff_addr inside {[OAM_START : OAM_END]};

  // CPU only regions stay on the CPU address
  assign hram_sel    = cpu_req.addr inside {[HRAM_START : HRAM_END]};
  assign dma_reg_sel = (cpu_req.addr == DMA_REG_ADDR);

  // Echo needs no remap, the RAM keeps only the low 13 bits
  assign wram_req = '{
    addr:     eff_addr,
    wdata:    cpu_req.wdata,
    read_en:  (cpu_rd || dma_rd) && wram_sel,
    write_en: cpu_wr && wram_sel
  };

  // ROM writes go out too, a cartridge mapper may listen to them
  assign cart_req = '{
    addr:     eff_addr,
    wdata:    cpu_req.wdata,
    read_en:  (cpu_rd || dma_rd) && cart_sel,
    write_en: cpu_wr && cart_sel
  };

  // DMA is the only master that writes OAM while active
  assign oam_req = '{
    addr:     {8'h00, eff_addr[7:0]},
    wdata:    dma_active ? dma_req.wdata : cpu_req.wdata,
    read_en:  cpu_rd && oam_sel,
    write_en: (cpu_wr || dma_wr) && oam_sel
  };

  // Offset from FF80
  assign hram_req = '{
    addr:     cpu_req.addr - HRAM_START,
    wdata:    cpu_req.wdata,
    read_en:  cpu_req.read_en && hram_sel,
    write_en: cpu_req.write_en && hram_sel
  };

  assign dma_start = cpu_req.write_en && dma_reg_sel;

  always_comb begin
    cpu_rdata = UNMAPPED_DATA;
    dma_rdata = UNMAPPED_DATA;

    if (dma_active) begin
      if (dma_reg_sel) begin
        cpu_rdata = dma_src;
      end else if (hram_sel) begin
        cpu_rdata = hram_rdata;
      end

      // Source page fetch
      if (wram_sel) begin
        dma_rdata = wram_rdata;
      end else if (cart_sel) begin
        dma_rdata = cart_rdata;
      end
    end else begin
      if (oam_sel) begin
        cpu_rdata = oam_rdata;
      end else if (cart_sel) begin
        cpu_rdata = cart_rdata;
      end else if (wram_sel) begin
        cpu_rdata = wram_rdata;
      end else if (hram_sel) begin
        cpu_rdata = hram_rdata;
      end else if (dma_reg_sel) begin
        cpu_rdata = dma_src;
      end
    end
  end

endmodule

// ==== hdl/oam_dma.sv ====
`timescale 1ns/1ps

module oam_dma (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic [7:0]           start_data,
  input  logic [7:0]           rdata,
  output gb_bus_pkg::dma_req_t req,
  output logic [7:0]           src
);
  import gb_bus_pkg::*;
  import gb_mem_map_pkg::*;

  logic        active;
  // Low for the fetch from the source page, high for the store into OAM
  logic        phase;
  logic [7:0]  idx;
  logic [7:0]  data_q;
  logic [15:0] src_addr;
  logic [15:0] dst_addr;
  logic        last_byte;

  assign src_addr  = {src, idx};
  assign dst_addr  = OAM_START + {8'h00, idx};
  assign last_byte = (idx == 8'(OAM_BYTES - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b0;
      phase  <= 1'b0;
      idx    <= 8'h00;
      src    <= 8'h00;
    end else if (!active) begin
      // A start while busy is dropped by this branch
      if (start) begin
        active <= 1'b1;
        src    <= start_data;
        idx    <= 8'h00;
        phase  <= 1'b0;
      end
    end else if (!phase) begin
      phase <= 1'b1;
    end else begin
      phase <= 1'b0;
      if (last_byte) begin
        active <= 1'b0;
      end else begin
        idx <= idx + 8'd1;
      end
    end
  end

  // Byte seen in the fetch cycle goes out in the store cycle
  always_ff @(posedge clk) begin
    if (active && !phase) begin
      data_q <= rdata;
    end
  end

  assign req = '{
    active:   active,
    addr:     phase ? dst_addr : src_addr,
    wdata:    data_q,
    read_en:  active && !phase,
    write_en: active && phase
  };

endmodule

// ==== hdl/byte_ram.sv ====
`timescale 1ns/1ps

module byte_ram #(
  parameter int DEPTH = 256
) (
  input  logic                 clk,
  input  gb_bus_pkg::bus_req_t req,
  output logic [7:0]           rdata
);
  import gb_mem_map_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  logic [7:0]       mem [DEPTH];
  logic [IDX_W-1:0] idx;

  // Mapper hands over a zero based offset for HRAM and OAM
  assign idx = IDX_W'(req.addr % DEPTH);

  assign rdata = req.read_en ? mem[idx] : UNMAPPED_DATA;

  always_ff @(posedge clk) begin
    if (req.write_en) begin
      mem[idx] <= req.wdata;
    end
  end

endmodule

// ==== hdl/gb_bus_pkg.sv ====
package gb_bus_pkg;

  // One byte access on a memory port, read data returns beside it
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } bus_req_t;

  // DMA side request, active marks ownership of the shared address
  typedef struct packed {
    logic        active;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        read_en;
    logic        write_en;
  } dma_req_t;

  // Bytes moved by one OAM DMA transfer
  localparam int OAM_BYTES = 160;

  // Work RAM, echo folds onto it
  localparam int WRAM_DEPTH = 8192;

  // High RAM, FF80 to FFFE
  localparam int HRAM_DEPTH = 127;

endpackage

// ==== hdl/gb_mem_map_pkg.sv ====
package gb_mem_map_pkg;

  // Cartridge ROM, both banks
  localparam logic [15:0] ROM_START = 16'h0000;
  localparam logic [15:0] ROM_END   = 16'h7FFF;

  // External RAM on the cartridge
  localparam logic [15:0] CART_RAM_START = 16'hA000;
  localparam logic [15:0] CART_RAM_END   = 16'hBFFF;

  // Work RAM
  localparam logic [15:0] WRAM_START = 16'hC000;
  localparam logic [15:0] WRAM_END   = 16'hDFFF;

  // Echo of work RAM, same low 13 address bits
  localparam logic [15:0] ECHO_START = 16'hE000;
  localparam logic [15:0] ECHO_END   = 16'hFDFF;

  // Sprite attribute table, 40 sprites of 4 bytes
  localparam logic [15:0] OAM_START = 16'hFE00;
  localparam logic [15:0] OAM_END   = 16'hFE9F;

  // OAM DMA source page register
  localparam logic [15:0] DMA_REG_ADDR = 16'hFF46;

  // High RAM, FFFF itself is the interrupt enable register and not here
  localparam logic [15:0] HRAM_START = 16'hFF80;
  localparam logic [15:0] HRAM_END   = 16'hFFFE;

  // Open bus value for regions with nothing behind them
  localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

endpackage
